//--- all.f
+incdir+verilog
+incdir+verif
verilog/cpu_isa_pkg.sv
verilog/cpu_host_pkg.sv
verilog/cpu_control.sv
verilog/instr_mem.sv
verilog/reg_file.sv
verilog/exec_stage.sv
verilog/cpu.sv
verif/cpu_tb.sv

//--- verif/cpu_tb_vectors.svh
/*
 * Program image and expected host writes for the CPU testbench.
 * Words are {opcode, rd, rs, imm}; rt of register forms sits in imm[15:12].
 * Unlisted words stay nop, so the tail after the last store runs idle.
 * Expected writes are worked out by hand, in the order the stores issue.
 */
`ifndef CPU_TB_VECTORS_SVH
`define CPU_TB_VECTORS_SVH

localparam int PROG_WORDS = `CPU_IM_WORDS;
localparam int N_WR       = 10;

logic [`CPU_WORD_W-1:0] prog [PROG_WORDS];
cpu_host_pkg::host_wr_t exp_wr [N_WR];

// immediate form, also used for stores (rd is the data register)
function automatic logic [31:0] encode_imm(input logic [7:0] opc, input logic [3:0] rd,
                                           input logic [3:0] rs, input logic [15:0] imm);
    return {opc, rd, rs, imm};
endfunction

function automatic logic [31:0] encode_reg(input logic [7:0] opc, input logic [3:0] rd,
                                           input logic [3:0] rs, input logic [3:0] rt);
    return {opc, rd, rs, rt, 12'h000};
endfunction

task automatic fill_vectors();
    for (int i = 0; i < PROG_WORDS; i++) begin
        prog[i] = 32'h0000_0000;                                    // nop
    end
    prog[0]  = encode_imm(cpu_isa_pkg::OP_ADDI,  4'd1,  4'd0,  16'h1234); // r1 = 0x1234
    prog[1]  = encode_imm(cpu_isa_pkg::OP_ADDI,  4'd2,  4'd0,  16'h0f0f); // r2 = 0x0f0f
    prog[2]  = encode_reg(cpu_isa_pkg::OP_ADD,   4'd3,  4'd1,  4'd2);
    prog[3]  = encode_imm(cpu_isa_pkg::OP_STORE, 4'd3,  4'd0,  16'h9000);
    prog[4]  = encode_reg(cpu_isa_pkg::OP_SUB,   4'd4,  4'd1,  4'd2);
    prog[5]  = encode_imm(cpu_isa_pkg::OP_STORE, 4'd4,  4'd0,  16'h9004);
    prog[6]  = encode_reg(cpu_isa_pkg::OP_AND,   4'd5,  4'd1,  4'd2);
    prog[7]  = encode_imm(cpu_isa_pkg::OP_STORE, 4'd5,  4'd0,  16'h9008);
    prog[8]  = encode_reg(cpu_isa_pkg::OP_OR,    4'd6,  4'd1,  4'd2);
    prog[9]  = encode_imm(cpu_isa_pkg::OP_STORE, 4'd6,  4'd0,  16'h900c);
    prog[10] = encode_reg(cpu_isa_pkg::OP_XOR,   4'd7,  4'd1,  4'd2);
    prog[11] = encode_imm(cpu_isa_pkg::OP_STORE, 4'd7,  4'd0,  16'h9010);
    prog[12] = encode_imm(cpu_isa_pkg::OP_ADDI,  4'd8,  4'd0,  16'h0100);
    prog[13] = encode_imm(cpu_isa_pkg::OP_STORE, 4'd1,  4'd0,  16'h1000); // below window
    prog[14] = encode_imm(cpu_isa_pkg::OP_STORE, 4'd8,  4'd8,  16'h9000); // base just written
    prog[15] = encode_imm(cpu_isa_pkg::OP_ADDI,  4'd9,  4'd9,  16'h0005);
    prog[16] = encode_reg(cpu_isa_pkg::OP_ADD,   4'd9,  4'd9,  4'd9);     // dependent chain
    prog[17] = encode_imm(cpu_isa_pkg::OP_STORE, 4'd9,  4'd0,  16'h9014);
    prog[18] = encode_reg(cpu_isa_pkg::OP_SUB,   4'd10, 4'd0,  4'd1);
    prog[19] = encode_imm(cpu_isa_pkg::OP_STORE, 4'd10, 4'd0,  16'h9018);
    prog[20] = encode_imm(cpu_isa_pkg::OP_STORE, 4'd10, 4'd0,  16'h8ffc); // one word below
    prog[21] = encode_reg(cpu_isa_pkg::OP_XOR,   4'd11, 4'd10, 4'd1);
    prog[22] = encode_imm(cpu_isa_pkg::OP_STORE, 4'd11, 4'd0,  16'hfffc);
    prog[23] = encode_imm(cpu_isa_pkg::OP_STORE, 4'd11, 4'd11, 16'h0000); // back-to-back

    // {address, data}
    exp_wr[0] = {16'h9000, 32'h0000_2143};      // add
    exp_wr[1] = {16'h9004, 32'h0000_0325};      // sub
    exp_wr[2] = {16'h9008, 32'h0000_0204};      // and
    exp_wr[3] = {16'h900c, 32'h0000_1f3f};      // or
    exp_wr[4] = {16'h9010, 32'h0000_1d3b};      // xor
    exp_wr[5] = {16'h9100, 32'h0000_0100};
    exp_wr[6] = {16'h9014, 32'h0000_000a};
    exp_wr[7] = {16'h9018, 32'hffff_edcc};
    exp_wr[8] = {16'hfffc, 32'hffff_fff8};
    exp_wr[9] = {16'hfff8, 32'hffff_fff8};
endtask

`endif

//--- verif/cpu_tb.sv
/*
 * CPU testbench with a host model on the plain op/ex_addr strobes.
 * Loads four program blocks, then serves each host write with tx_done
 * after a random 1 to 5 cycle delay and checks it against the table.
 * Inputs change on the falling edge, outputs are sampled there too.
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

    logic                   clk;
    logic                   rst_n;
    logic                   ready;
    logic                   rd_valid;
    logic                   tx_done;
    logic [`CPU_WORD_W-1:0] ex_wrt_data;
    cpu_host_pkg::host_op_e op;
    logic [`CPU_ADDR_W-1:0] ex_addr;
    logic [`CPU_WORD_W-1:0] ex_rd_data;
    int                     cycle_count;
    int unsigned            seed;

    `include "cpu_tb_vectors.svh"

    // load term plus program term, doubled
    localparam int TIMEOUT_CYCLES = 2 * (`CPU_IM_BLOCKS * (`CPU_BLOCK_WORDS + 5) +
                                         N_WR * 5 + PROG_WORDS * 4);
    localparam int QUIET_CYCLES   = 16;     // well inside the nop tail

    cpu uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready      (ready),
        .rd_valid   (rd_valid),
        .tx_done    (tx_done),
        .ex_wrt_data(ex_wrt_data),
        .op         (op),
        .ex_addr    (ex_addr),
        .ex_rd_data (ex_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // host model
    //////////////////////////////////////////////////////////////////////

    task automatic load_block(input int blk);
        logic [`CPU_ADDR_W-1:0] base;
        int                     delay;
        base  = `CPU_ADDR_W'(blk * `CPU_BLOCK_WORDS * 4);
        delay = 1 + $urandom % 5;
        repeat (delay) begin
            @(negedge clk);
            check_value("op", op, cpu_host_pkg::HOST_READ);
            check_value("ex_addr", ex_addr, base);
        end
        rd_valid    = 1'b1;                     // word 0 goes with the strobe
        ex_wrt_data = prog[blk * `CPU_BLOCK_WORDS];
        for (int w = 1; w < `CPU_BLOCK_WORDS; w++) begin
            @(negedge clk);
            check_value("op", op, cpu_host_pkg::HOST_READ);
            check_value("ex_addr", ex_addr, base);
            rd_valid    = 1'b0;
            ex_wrt_data = prog[blk * `CPU_BLOCK_WORDS + w];
            tx_done     = (w == `CPU_BLOCK_WORDS - 1);  // with the last word
        end
        @(negedge clk);
        tx_done = 1'b0;
    endtask

    task automatic serve_write(input int idx);
        int delay;
        while (op !== cpu_host_pkg::HOST_WRITE) begin
            check_value("op", op, cpu_host_pkg::HOST_IDLE);     // no read after load
            @(negedge clk);
        end
        check_value("ex_addr", ex_addr, exp_wr[idx].addr);
        check_value("ex_rd_data", ex_rd_data, exp_wr[idx].data);
        delay = 1 + $urandom % 5;
        repeat (delay) begin                    // request must hold until tx_done
            @(negedge clk);
            check_value("op", op, cpu_host_pkg::HOST_WRITE);
            check_value("ex_addr", ex_addr, exp_wr[idx].addr);
            check_value("ex_rd_data", ex_rd_data, exp_wr[idx].data);
        end
        tx_done = 1'b1;
        @(negedge clk);
        tx_done = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence and timeout
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed        = $urandom(24414);
        rst_n       = 1'b0;
        ready       = 1'b0;
        rd_valid    = 1'b0;
        tx_done     = 1'b0;
        ex_wrt_data = '0;
        fill_vectors();
        repeat (3) begin
            @(negedge clk);
            check_value("op", op, cpu_host_pkg::HOST_IDLE);
        end
        rst_n = 1'b1;
        repeat (2) begin                        // stays idle without ready
            @(negedge clk);
            check_value("op", op, cpu_host_pkg::HOST_IDLE);
        end
        ready = 1'b1;
        for (int b = 0; b < `CPU_IM_BLOCKS; b++) begin
            load_block(b);
        end
        check_value("op", op, cpu_host_pkg::HOST_IDLE);         // exactly four blocks
        for (int i = 0; i < N_WR; i++) begin
            serve_write(i);
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_value("op", op, cpu_host_pkg::HOST_IDLE);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run($sformatf("timeout: run did not complete within %0d cycles",
                            TIMEOUT_CYCLES));
    end

endmodule

//--- verilog/cpu.sv
/*
 * CPU top: controller with instruction RAM, register file and execute stage.
 * Host side is plain levels and strobes, no handshake beyond tx_done.
 * Reads load the program at start-up; writes come from host window stores.
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ready,
    input  logic                   rd_valid,
    input  logic                   tx_done,
    input  logic [`CPU_WORD_W-1:0] ex_wrt_data,
    output cpu_host_pkg::host_op_e op,
    output logic [`CPU_ADDR_W-1:0] ex_addr,
    output logic [`CPU_WORD_W-1:0] ex_rd_data
);

    cpu_isa_pkg::instr_t    im_rdata;
    cpu_isa_pkg::rf_wr_t    ex_dst, wb;
    cpu_isa_pkg::dec_t      dec;
    cpu_host_pkg::host_wr_t host_wr;
    logic                   host_req;
    logic                   im_wen, im_hold;
    logic [`CPU_ADDR_W-1:0] im_waddr, fetch_pc;
    logic [`CPU_WORD_W-1:0] im_wdata;
    logic [`CPU_REG_AW-1:0] rs_sel, rt_sel;
    logic [`CPU_WORD_W-1:0] rs_data, rt_data;
    logic                   advance;

    assign im_hold = !advance;

    cpu_control u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready      (ready),
        .rd_valid   (rd_valid),
        .tx_done    (tx_done),
        .ex_wrt_data(ex_wrt_data),
        .im_rdata   (im_rdata),
        .ex_dst     (ex_dst),
        .wb         (wb),
        .host_req   (host_req),
        .host_wr    (host_wr),
        .op         (op),
        .ex_addr    (ex_addr),
        .ex_rd_data (ex_rd_data),
        .im_wen     (im_wen),
        .im_waddr   (im_waddr),
        .im_wdata   (im_wdata),
        .fetch_pc   (fetch_pc),
        .rs_sel     (rs_sel),
        .rt_sel     (rt_sel),
        .dec        (dec),
        .advance    (advance)
    );

    instr_mem u_imem (
        .clk  (clk),
        .wen  (im_wen),
        .waddr(im_waddr),
        .wdata(im_wdata),
        .raddr(fetch_pc),
        .hold (im_hold),
        .rdata(im_rdata)
    );

    reg_file u_rf (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs_sel (rs_sel),
        .rt_sel (rt_sel),
        .wr     (wb),
        .rs_data(rs_data),
        .rt_data(rt_data)
    );

    exec_stage u_exec (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .dec     (dec),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .ex_dst  (ex_dst),
        .host_req(host_req),
        .host_wr (host_wr),
        .wb      (wb)
    );

endmodule

//--- verilog/exec_stage.sv
/*
 * Execute and writeback: decode/execute register, ALU, writeback register.
 * A store at or above CPU_HOST_BASE raises host_req from execute; lower
 * stores are discarded. Only the low CPU_ADDR_W bits form the address.
 * Both registers move only on advance.
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module exec_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   advance,
    input  cpu_isa_pkg::dec_t      dec,
    input  logic [`CPU_WORD_W-1:0] rs_data,
    input  logic [`CPU_WORD_W-1:0] rt_data,
    output cpu_isa_pkg::rf_wr_t    ex_dst,
    output logic                   host_req,
    output cpu_host_pkg::host_wr_t host_wr,
    output cpu_isa_pkg::rf_wr_t    wb
);

    cpu_isa_pkg::dec_t      dec_q;
    logic [`CPU_WORD_W-1:0] rs_q, rt_q;
    logic [`CPU_WORD_W-1:0] alu_b, alu_out;

    //////////////////////////////////////////////////////////////////////
    // decode/execute register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) dec_q <= '0;            // bubble
        else if (advance) dec_q <= dec;
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            rs_q <= rs_data;
            rt_q <= rt_data;
        end
    end

    // alu
    assign alu_b = dec_q.use_imm ? dec_q.imm : rt_q;

    always_comb begin
        case (dec_q.alu_op)
            cpu_isa_pkg::ALU_ADD: alu_out = rs_q + alu_b;
            cpu_isa_pkg::ALU_SUB: alu_out = rs_q - alu_b;
            cpu_isa_pkg::ALU_AND: alu_out = rs_q & alu_b;
            cpu_isa_pkg::ALU_OR:  alu_out = rs_q | alu_b;
            cpu_isa_pkg::ALU_XOR: alu_out = rs_q ^ alu_b;
            default:              alu_out = alu_b;
        endcase
    end

    assign ex_dst = '{wen: dec_q.rf_wen, addr: dec_q.rd, data: '0};

    // host window store
    assign host_req = dec_q.store && (alu_out[`CPU_ADDR_W-1:0] >= `CPU_HOST_BASE);
    assign host_wr  = '{addr: alu_out[`CPU_ADDR_W-1:0], data: rt_q};

    //////////////////////////////////////////////////////////////////////
    // writeback register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (advance) begin
            wb.wen  <= dec_q.rf_wen;        // stores never write back
            wb.addr <= dec_q.rd;
            wb.data <= alu_out;
        end
    end

endmodule

//--- verilog/reg_file.sv
/*
 * General register file, CPU_REG_NUM x CPU_WORD_W, all cleared at reset.
 * Two combinational reads, one synchronous write.
 * No write-to-read bypass; the decode stall keeps readers off a pending write.
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_REG_AW-1:0] rs_sel,
    input  logic [`CPU_REG_AW-1:0] rt_sel,
    input  cpu_isa_pkg::rf_wr_t    wr,
    output logic [`CPU_WORD_W-1:0] rs_data,
    output logic [`CPU_WORD_W-1:0] rt_data
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_REG_NUM];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.wen) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rs_data = regs[rs_sel];
    assign rt_data = regs[rt_sel];      // rd for stores

endmodule

//--- verilog/instr_mem.sv
/*
 * Instruction RAM, CPU_IM_WORDS words, indexed by byte address bits above 1:0.
 * Read is registered with one cycle of latency and holds while hold is high.
 * The read register has no reset; the controller masks it until first fetch.
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instr_mem (
    input  logic                   clk,
    input  logic                   wen,
    input  logic [`CPU_ADDR_W-1:0] waddr,
    input  logic [`CPU_WORD_W-1:0] wdata,
    input  logic [`CPU_ADDR_W-1:0] raddr,
    input  logic                   hold,
    output cpu_isa_pkg::instr_t    rdata
);

    localparam int IDX_W = $clog2(`CPU_IM_WORDS);

    cpu_isa_pkg::instr_t mem [`CPU_IM_WORDS];

    // loader write port
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr[IDX_W+1:2]] <= cpu_isa_pkg::instr_t'(wdata);
        end
    end

    // fetch port
    always_ff @(posedge clk) begin
        if (!hold) begin
            rdata <= mem[raddr[IDX_W+1:2]];
        end
    end

endmodule

//--- verilog/cpu_control.sv
/*
 * Controller: host loader FSM, program counter, decoder and RAW stall.
 * advance is the pipeline enable and drops only for a host freeze.
 * A hazard holds the pc and refetches the decode word; a nop goes to execute.
 * No forwarding; a dependent instruction waits until its writer retires.
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_control (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ready,
    input  logic                        rd_valid,
    input  logic                        tx_done,
    input  logic [`CPU_WORD_W-1:0]      ex_wrt_data,
    input  cpu_isa_pkg::instr_t         im_rdata,
    input  cpu_isa_pkg::rf_wr_t         ex_dst,
    input  cpu_isa_pkg::rf_wr_t         wb,
    input  logic                        host_req,
    input  cpu_host_pkg::host_wr_t      host_wr,
    output cpu_host_pkg::host_op_e      op,
    output logic [`CPU_ADDR_W-1:0]      ex_addr,
    output logic [`CPU_WORD_W-1:0]      ex_rd_data,
    output logic                        im_wen,
    output logic [`CPU_ADDR_W-1:0]      im_waddr,
    output logic [`CPU_WORD_W-1:0]      im_wdata,
    output logic [`CPU_ADDR_W-1:0]      fetch_pc,
    output logic [`CPU_REG_AW-1:0]      rs_sel,
    output logic [`CPU_REG_AW-1:0]      rt_sel,
    output cpu_isa_pkg::dec_t           dec,
    output logic                        advance
);

    localparam int BLK_SHIFT = $clog2(`CPU_BLOCK_WORDS * 4);
    localparam int BLK_CW    = $clog2(`CPU_IM_BLOCKS);
    localparam logic [`CPU_ADDR_W-1:0] PC_MASK = `CPU_ADDR_W'(`CPU_IM_WORDS * 4 - 1);

    cpu_host_pkg::load_state_e state, next_state;
    logic [BLK_CW-1:0]         blk_cnt;
    logic [`CPU_ADDR_W-1:0]    block_base;
    logic [`CPU_ADDR_W-1:0]    load_addr;
    logic                      load_set, load_inc, blk_inc;
    logic [`CPU_ADDR_W-1:0]    pc, dec_pc;     // next fetch, word now in decode
    logic                      dec_valid;
    cpu_isa_pkg::dec_t         dec_raw;
    logic                      use_rs, use_rt, stall;

    // register sel is written by an instruction still in flight
    function automatic logic pending(input logic [`CPU_REG_AW-1:0] sel,
                                     input cpu_isa_pkg::rf_wr_t a,
                                     input cpu_isa_pkg::rf_wr_t b);
        return (a.wen && a.addr == sel) || (b.wen && b.addr == sel);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // loader and host write FSM
    //////////////////////////////////////////////////////////////////////

    assign block_base = `CPU_ADDR_W'(blk_cnt) << BLK_SHIFT;
    assign im_wdata   = ex_wrt_data;

    always_comb begin
        next_state = state;
        op         = cpu_host_pkg::HOST_IDLE;
        ex_addr    = '0;
        ex_rd_data = '0;
        im_wen     = 1'b0;
        im_waddr   = load_addr;
        advance    = 1'b0;
        load_set   = 1'b0;
        load_inc   = 1'b0;
        blk_inc    = 1'b0;
        case (state)
            cpu_host_pkg::CPU_IDLE: begin
                if (ready) next_state = cpu_host_pkg::WAIT_INIT_IM;
            end
            cpu_host_pkg::WAIT_INIT_IM: begin
                op       = cpu_host_pkg::HOST_READ;
                ex_addr  = block_base;
                im_waddr = block_base;          // word 0 lands at the base
                if (rd_valid) begin
                    im_wen     = 1'b1;
                    load_set   = 1'b1;
                    next_state = cpu_host_pkg::INIT_IM;
                end
            end
            cpu_host_pkg::INIT_IM: begin
                op       = cpu_host_pkg::HOST_READ;
                ex_addr  = block_base;
                im_wen   = 1'b1;                // one word per cycle
                load_inc = 1'b1;
                if (tx_done) begin
                    if (blk_cnt == BLK_CW'(`CPU_IM_BLOCKS - 1)) begin
                        next_state = cpu_host_pkg::RUN;
                    end else begin
                        blk_inc    = 1'b1;
                        next_state = cpu_host_pkg::WAIT_INIT_IM;
                    end
                end
            end
            cpu_host_pkg::RUN: begin
                if (host_req) begin             // freeze starts this cycle
                    op         = cpu_host_pkg::HOST_WRITE;
                    ex_addr    = host_wr.addr;
                    ex_rd_data = host_wr.data;
                    next_state = cpu_host_pkg::WRT_HOST;
                end else begin
                    advance = 1'b1;
                end
            end
            cpu_host_pkg::WRT_HOST: begin
                op         = cpu_host_pkg::HOST_WRITE;
                ex_addr    = host_wr.addr;      // execute is frozen, so stable
                ex_rd_data = host_wr.data;
                if (tx_done) begin
                    advance    = 1'b1;
                    next_state = cpu_host_pkg::RUN;
                end
            end
            default: next_state = cpu_host_pkg::CPU_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cpu_host_pkg::CPU_IDLE;
            blk_cnt   <= '0;
            load_addr <= '0;
        end else begin
            state <= next_state;
            if (blk_inc) blk_cnt <= blk_cnt + 1'b1;
            if (load_set) load_addr <= block_base + `CPU_ADDR_W'(4);
            else if (load_inc) load_addr <= load_addr + `CPU_ADDR_W'(4);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode and hazard stall
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dec_raw     = '0;
        dec_raw.rd  = im_rdata.rd;
        dec_raw.imm = `CPU_WORD_W'(im_rdata.imm);   // zero-extended
        use_rs      = 1'b1;
        use_rt      = 1'b1;
        dec_raw.rf_wen = 1'b1;
        case (im_rdata.opcode)
            cpu_isa_pkg::OP_ADD: dec_raw.alu_op = cpu_isa_pkg::ALU_ADD;
            cpu_isa_pkg::OP_SUB: dec_raw.alu_op = cpu_isa_pkg::ALU_SUB;
            cpu_isa_pkg::OP_AND: dec_raw.alu_op = cpu_isa_pkg::ALU_AND;
            cpu_isa_pkg::OP_OR:  dec_raw.alu_op = cpu_isa_pkg::ALU_OR;
            cpu_isa_pkg::OP_XOR: dec_raw.alu_op = cpu_isa_pkg::ALU_XOR;
            cpu_isa_pkg::OP_ADDI: begin
                dec_raw.alu_op  = cpu_isa_pkg::ALU_ADD;
                dec_raw.use_imm = 1'b1;
                use_rt          = 1'b0;
            end
            cpu_isa_pkg::OP_STORE: begin        // address rs + imm, data from rd
                dec_raw.alu_op  = cpu_isa_pkg::ALU_ADD;
                dec_raw.use_imm = 1'b1;
                dec_raw.store   = 1'b1;
                dec_raw.rf_wen  = 1'b0;
            end
            default: begin                      // nop and unused codes
                dec_raw.rf_wen = 1'b0;
                use_rs         = 1'b0;
                use_rt         = 1'b0;
            end
        endcase
    end

    assign rs_sel = im_rdata.rs;
    assign rt_sel = (im_rdata.opcode == cpu_isa_pkg::OP_STORE) ? im_rdata.rd
                                                               : im_rdata.imm[15:12];

    assign stall = dec_valid && ((use_rs && pending(rs_sel, ex_dst, wb)) ||
                                 (use_rt && pending(rt_sel, ex_dst, wb)));

    assign dec      = (stall || !dec_valid) ? '0 : dec_raw;    // bubble is all zero
    assign fetch_pc = stall ? dec_pc : pc;                     // refetch on stall

    //////////////////////////////////////////////////////////////////////
    // program counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= '0;
            dec_pc    <= '0;
            dec_valid <= 1'b0;
        end else if (advance) begin
            dec_valid <= 1'b1;                  // first real fetch issued
            dec_pc    <= fetch_pc;
            if (!stall) pc <= (pc + `CPU_ADDR_W'(4)) & PC_MASK;
        end
    end

endmodule

//--- verilog/cpu_host_pkg.sv
/*
 * Host side types: bus operation, host write payload, controller states.
 */
`include "cpu_consts.svh"

package cpu_host_pkg;

    typedef enum logic [1:0] {
        HOST_IDLE  = 2'b00,
        HOST_READ  = 2'b01,
        HOST_WRITE = 2'b11
    } host_op_e;

    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_WORD_W-1:0] data;
    } host_wr_t;

    typedef enum logic [2:0] {
        CPU_IDLE,
        WAIT_INIT_IM,
        INIT_IM,
        RUN,
        WRT_HOST
    } load_state_e;

endpackage

//--- verilog/cpu_isa_pkg.sv
/*
 * Instruction set types: encoding, decoded control word, register write.
 * The immediate is zero-extended; rt shares bits 15:12 with the immediate.
 */
`include "cpu_consts.svh"

package cpu_isa_pkg;

    typedef enum logic [7:0] {
        OP_NOP   = 8'h00,
        OP_ADD   = 8'h10,
        OP_SUB   = 8'h11,
        OP_AND   = 8'h12,
        OP_OR    = 8'h13,
        OP_XOR   = 8'h14,
        OP_ADDI  = 8'h18,
        OP_STORE = 8'h83
    } opcode_e;

    typedef logic [`CPU_REG_AW-1:0] reg_sel_t;

    // rt is imm[15:12] for register-register forms
    typedef struct packed {
        opcode_e     opcode;
        reg_sel_t    rd;
        reg_sel_t    rs;
        logic [15:0] imm;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        alu_op_e                alu_op;
        logic                   use_imm;
        logic                   rf_wen;
        logic                   store;
        reg_sel_t               rd;
        logic [`CPU_WORD_W-1:0] imm;
    } dec_t;

    typedef struct packed {
        logic                   wen;
        reg_sel_t               addr;
        logic [`CPU_WORD_W-1:0] data;
    } rf_wr_t;

endpackage

//--- verilog/cpu_consts.svh
/*
 * Widths, geometry and address map shared by the CPU and its testbench.
 * Instruction memory is byte addressed, word aligned, and holds
 * CPU_IM_BLOCKS blocks of CPU_BLOCK_WORDS words loaded by the host.
 * Stores at or above CPU_HOST_BASE go to the host; lower ones are dropped.
 */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and bus widths
`define CPU_WORD_W      32
`define CPU_ADDR_W      16
`define CPU_REG_AW      4
`define CPU_REG_NUM     16

// host load geometry
`define CPU_BLOCK_WORDS 16
`define CPU_IM_BLOCKS   4
`define CPU_IM_WORDS    64      // 256 bytes, pc wraps here

// start of the host write window
`define CPU_HOST_BASE   16'h9000

`endif
